// ==== lsu_defines.svh ====
// load/store unit parameters
`ifndef LSU_DEFINES_SVH
`define LSU_DEFINES_SVH

// number of SIMD lanes
`define LSU_NUM_LANES 2

// data and byte address width
`define LSU_XLEN 32

// bytes per memory word
`define LSU_WORD_BYTES 4

// word address width
`define LSU_MEM_ADDR_BITS 30

// warp id width
`define LSU_NW_BITS 2

// destination register index width
`define LSU_NR_BITS 5

// max loads in flight
`define LSU_QUEUE_SIZE 4

`endif

// ==== lsu_pending_queue.sv ====
// pending-load tag queue
`include "lsu_defines.svh"

module lsu_pending_queue (
    input  logic                clk,
    input  logic                reset,

    input  logic                q_push,
    input  lsu_pkg::lsu_tag_t   q_push_tag,
    input  logic                q_pop,

    output lsu_pkg::lsu_tag_t   q_head,
    output logic                q_empty,
    output logic                q_full
);

    localparam int PTR_W = (`LSU_QUEUE_SIZE > 1) ? $clog2(`LSU_QUEUE_SIZE) : 1;
    localparam int CNT_W = $clog2(`LSU_QUEUE_SIZE + 1);

    lsu_pkg::lsu_tag_t  entries [`LSU_QUEUE_SIZE];
    logic [PTR_W-1:0]   wr_ptr;
    logic [PTR_W-1:0]   rd_ptr;
    logic [CNT_W-1:0]   count;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(`LSU_QUEUE_SIZE - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    always_ff @(posedge clk) begin
        if (q_push) begin
            entries[wr_ptr] <= q_push_tag;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (q_push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (q_pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            // simultaneous push and pop leave the count alone
            if (q_push && !q_pop) begin
                count <= count + 1'b1;
            end else if (q_pop && !q_push) begin
                count <= count - 1'b1;
            end
        end
    end

    assign q_head  = entries[rd_ptr];
    assign q_empty = (count == '0);
    assign q_full  = (count == CNT_W'(`LSU_QUEUE_SIZE));

endmodule

// ==== lsu_pkg.sv ====
// instruction-side types
`include "lsu_defines.svh"

package lsu_pkg;

    // size codes shared by both views of the op
    localparam logic [1:0] SIZE_BYTE = 2'd0;
    localparam logic [1:0] SIZE_HALF = 2'd1;
    localparam logic [1:0] SIZE_WORD = 2'd2;

    typedef logic [$clog2(`LSU_WORD_BYTES)-1:0] align_t;

    typedef struct packed {
        logic       is_unsigned;
        logic [1:0] size;
    } lsu_ld_op_t;

    typedef struct packed {
        logic       rsvd;
        logic [1:0] size;
    } lsu_st_op_t;

    // one op word, decoded per access direction
    typedef union packed {
        lsu_ld_op_t ld;
        lsu_st_op_t st;
    } lsu_op_u;

    typedef struct packed {
        logic [`LSU_NW_BITS-1:0]                    wid;
        logic [`LSU_XLEN-1:0]                       pc;
        logic [`LSU_NUM_LANES-1:0]                  tmask;
        logic [`LSU_NR_BITS-1:0]                    rd;
        logic                                       is_load;
        logic                                       is_fence;
        lsu_op_u                                    op;
        logic [`LSU_NUM_LANES-1:0][`LSU_XLEN-1:0]   rs1;
        logic [`LSU_NUM_LANES-1:0][`LSU_XLEN-1:0]   rs2;
        logic [`LSU_XLEN-1:0]                       imm;
    } lsu_dispatch_t;

    // kept per pending load until its response
    typedef struct packed {
        logic [`LSU_NW_BITS-1:0]        wid;
        logic [`LSU_XLEN-1:0]           pc;
        logic [`LSU_NUM_LANES-1:0]      tmask;
        logic [`LSU_NR_BITS-1:0]        rd;
        lsu_op_u                        op;
        align_t [`LSU_NUM_LANES-1:0]    align;
    } lsu_tag_t;

    typedef struct packed {
        logic [`LSU_NW_BITS-1:0]                    wid;
        logic [`LSU_XLEN-1:0]                       pc;
        logic [`LSU_NUM_LANES-1:0]                  tmask;
        logic [`LSU_NR_BITS-1:0]                    rd;
        logic                                       wb;
        logic [`LSU_NUM_LANES-1:0][`LSU_XLEN-1:0]   data;
    } lsu_commit_t;

endpackage

// ==== lsu_req_format.sv ====
// load/store request formatter
`include "lsu_defines.svh"

module lsu_req_format (
    input  logic                    dispatch_valid,
    input  lsu_pkg::lsu_dispatch_t  dispatch,
    output logic                    dispatch_ready,

    output logic                    mem_req_valid,
    output mem_pkg::mem_req_t       mem_req,
    input  logic                    mem_req_ready,

    output logic                    q_push,
    output lsu_pkg::lsu_tag_t       q_push_tag,
    input  logic                    q_empty,
    input  logic                    q_full,

    output logic                    st_valid,
    output lsu_pkg::lsu_commit_t    st_commit,
    input  logic                    st_ready
);

    localparam int ALIGN_BITS = $bits(lsu_pkg::align_t);

    logic [`LSU_NUM_LANES-1:0][`LSU_XLEN-1:0] full_addr;
    lsu_pkg::align_t [`LSU_NUM_LANES-1:0]     align;
    logic                                     is_load;
    logic                                     is_fence;
    logic                                     dispatch_fire;

    assign is_load  = dispatch.is_load;
    assign is_fence = dispatch.is_fence;

    // base plus immediate, split into word and byte offset
    always_comb begin
        for (int i = 0; i < `LSU_NUM_LANES; i++) begin
            full_addr[i] = dispatch.rs1[i] + dispatch.imm;
            align[i]     = full_addr[i][ALIGN_BITS-1:0];
        end
    end

    // fence waits for the pending-load queue to drain
    always_comb begin
        if (is_fence) begin
            dispatch_ready = q_empty & st_ready;
        end else if (is_load) begin
            dispatch_ready = mem_req_ready & ~q_full;
        end else begin
            dispatch_ready = mem_req_ready & st_ready;
        end
    end

    // gated so that a memory transfer always matches a dispatch transfer
    assign mem_req_valid = dispatch_valid & ~is_fence & (is_load ? ~q_full : st_ready);
    assign dispatch_fire = dispatch_valid & dispatch_ready;

    always_comb begin
        mem_req.rw   = ~is_load;
        mem_req.mask = dispatch.tmask;
        for (int i = 0; i < `LSU_NUM_LANES; i++) begin
            mem_req.addr[i] = full_addr[i][`LSU_XLEN-1 -: `LSU_MEM_ADDR_BITS];

            mem_req.byteen[i] = '0;
            case (dispatch.op.st.size)
                lsu_pkg::SIZE_BYTE: begin
                    mem_req.byteen[i][align[i]] = 1'b1;
                end
                lsu_pkg::SIZE_HALF: begin
                    mem_req.byteen[i][{align[i][ALIGN_BITS-1:1], 1'b0}] = 1'b1;
                    mem_req.byteen[i][{align[i][ALIGN_BITS-1:1], 1'b1}] = 1'b1;
                end
                default: begin
                    mem_req.byteen[i] = '1;
                end
            endcase

            // move store data into its byte lane
            mem_req.data[i] = dispatch.rs2[i] << {align[i], 3'b000};
        end
    end

    assign q_push = dispatch_fire & is_load;

    always_comb begin
        q_push_tag.wid   = dispatch.wid;
        q_push_tag.pc    = dispatch.pc;
        q_push_tag.tmask = dispatch.tmask;
        q_push_tag.rd    = dispatch.rd;
        q_push_tag.op    = dispatch.op;
        q_push_tag.align = align;
    end

    // stores and fences commit straight away
    assign st_valid = dispatch_fire & ~is_load;

    always_comb begin
        st_commit.wid   = dispatch.wid;
        st_commit.pc    = dispatch.pc;
        st_commit.tmask = dispatch.tmask;
        st_commit.rd    = dispatch.rd;
        st_commit.wb    = 1'b0;
        st_commit.data  = '0;
    end

endmodule

// ==== lsu_rsp_format.sv ====
// load response formatter and commit stage
`include "lsu_defines.svh"

module lsu_rsp_format (
    input  logic                    clk,
    input  logic                    reset,

    input  logic                    mem_rsp_valid,
    input  mem_pkg::mem_rsp_t       mem_rsp,
    output logic                    mem_rsp_ready,

    input  lsu_pkg::lsu_tag_t       q_head,
    output logic                    q_pop,

    input  logic                    st_valid,
    input  lsu_pkg::lsu_commit_t    st_commit,
    output logic                    st_ready,

    output logic                    commit_valid,
    output lsu_pkg::lsu_commit_t    commit,
    input  logic                    commit_ready
);

    logic                   slot_free;
    logic                   rsp_fire;
    logic                   st_fire;
    lsu_pkg::lsu_commit_t   ld_commit;

    // narrow each lane's word by its byte offset, then extend
    always_comb begin
        logic [15:0] half_v;
        logic [7:0]  byte_v;
        logic        sign_v;

        ld_commit.wid   = q_head.wid;
        ld_commit.pc    = q_head.pc;
        ld_commit.tmask = q_head.tmask;
        ld_commit.rd    = q_head.rd;
        ld_commit.wb    = 1'b1;

        for (int i = 0; i < `LSU_NUM_LANES; i++) begin
            half_v = q_head.align[i][1] ? mem_rsp.data[i][31:16] : mem_rsp.data[i][15:0];
            byte_v = q_head.align[i][0] ? half_v[15:8] : half_v[7:0];
            case (q_head.op.ld.size)
                lsu_pkg::SIZE_BYTE: begin
                    sign_v = byte_v[7] & ~q_head.op.ld.is_unsigned;
                    ld_commit.data[i] = {{(`LSU_XLEN-8){sign_v}}, byte_v};
                end
                lsu_pkg::SIZE_HALF: begin
                    sign_v = half_v[15] & ~q_head.op.ld.is_unsigned;
                    ld_commit.data[i] = {{(`LSU_XLEN-16){sign_v}}, half_v};
                end
                default: begin
                    sign_v = 1'b0;
                    ld_commit.data[i] = mem_rsp.data[i];
                end
            endcase
        end
    end

    // single-entry commit register, loads win over stores
    assign slot_free     = ~commit_valid | commit_ready;
    assign mem_rsp_ready = slot_free;
    assign st_ready      = slot_free & ~mem_rsp_valid;

    assign rsp_fire = mem_rsp_valid & mem_rsp_ready;
    assign st_fire  = st_valid & st_ready;
    assign q_pop    = rsp_fire;

    always_ff @(posedge clk) begin
        if (reset) begin
            commit_valid <= 1'b0;
        end else if (rsp_fire || st_fire) begin
            commit_valid <= 1'b1;
        end else if (commit_ready) begin
            commit_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rsp_fire) begin
            commit <= ld_commit;
        end else if (st_fire) begin
            commit <= st_commit;
        end
    end

endmodule

// ==== lsu_unit.sv ====
// load/store unit top level
module lsu_unit (
    input  logic                    clk,
    input  logic                    reset,

    // dispatch
    input  logic                    dispatch_valid,
    input  lsu_pkg::lsu_dispatch_t  dispatch,
    output logic                    dispatch_ready,

    // memory request
    output logic                    mem_req_valid,
    output mem_pkg::mem_req_t       mem_req,
    input  logic                    mem_req_ready,

    // memory response
    input  logic                    mem_rsp_valid,
    input  mem_pkg::mem_rsp_t       mem_rsp,
    output logic                    mem_rsp_ready,

    // commit
    output logic                    commit_valid,
    output lsu_pkg::lsu_commit_t    commit,
    input  logic                    commit_ready
);

    logic                   q_push;
    lsu_pkg::lsu_tag_t      q_push_tag;
    logic                   q_pop;
    lsu_pkg::lsu_tag_t      q_head;
    logic                   q_empty;
    logic                   q_full;
    logic                   st_valid;
    lsu_pkg::lsu_commit_t   st_commit;
    logic                   st_ready;

    lsu_req_format req_format_inst (
        .dispatch_valid (dispatch_valid),
        .dispatch       (dispatch),
        .dispatch_ready (dispatch_ready),
        .mem_req_valid  (mem_req_valid),
        .mem_req        (mem_req),
        .mem_req_ready  (mem_req_ready),
        .q_push         (q_push),
        .q_push_tag     (q_push_tag),
        .q_empty        (q_empty),
        .q_full         (q_full),
        .st_valid       (st_valid),
        .st_commit      (st_commit),
        .st_ready       (st_ready)
    );

    lsu_pending_queue pending_queue_inst (
        .clk        (clk),
        .reset      (reset),
        .q_push     (q_push),
        .q_push_tag (q_push_tag),
        .q_pop      (q_pop),
        .q_head     (q_head),
        .q_empty    (q_empty),
        .q_full     (q_full)
    );

    lsu_rsp_format rsp_format_inst (
        .clk            (clk),
        .reset          (reset),
        .mem_rsp_valid  (mem_rsp_valid),
        .mem_rsp        (mem_rsp),
        .mem_rsp_ready  (mem_rsp_ready),
        .q_head         (q_head),
        .q_pop          (q_pop),
        .st_valid       (st_valid),
        .st_commit      (st_commit),
        .st_ready       (st_ready),
        .commit_valid   (commit_valid),
        .commit         (commit),
        .commit_ready   (commit_ready)
    );

endmodule

// ==== lsu_unit_props.sv ====
// lsu_unit protocol checks
`include "lsu_defines.svh"

module lsu_unit_props (
    input logic                     clk,
    input logic                     reset,
    input logic                     dispatch_valid,
    input lsu_pkg::lsu_dispatch_t   dispatch,
    input logic                     dispatch_ready,
    input logic                     commit_valid,
    input lsu_pkg::lsu_commit_t     commit,
    input logic                     commit_ready,
    input logic                     q_pop,
    input logic                     q_empty
);

    int unsigned fail_count = 0;

    // inactive lanes are not checked
    // byte accesses are always aligned
    function automatic logic lanes_aligned(input lsu_pkg::lsu_dispatch_t d);
        logic [`LSU_XLEN-1:0] addr;
        logic                 ok;
        ok = 1'b1;
        for (int i = 0; i < `LSU_NUM_LANES; i++) begin
            addr = d.rs1[i] + d.imm;
            if (d.tmask[i] && d.op.st.size == lsu_pkg::SIZE_HALF && addr[0]) begin
                ok = 1'b0;
            end
            if (d.tmask[i] && d.op.st.size == lsu_pkg::SIZE_WORD && addr[1:0] != 2'b00) begin
                ok = 1'b0;
            end
        end
        return ok;
    endfunction

    aligned_access: assert property (@(posedge clk) disable iff (reset)
        dispatch_valid && dispatch_ready && !dispatch.is_fence |-> lanes_aligned(dispatch))
        else begin
            fail_count++;
            $error("misaligned load or store was dispatched");
        end

    commit_held: assert property (@(posedge clk) disable iff (reset)
        commit_valid && !commit_ready |=> commit_valid && $stable(commit))
        else begin
            fail_count++;
            $error("commit changed while stalled");
        end

    pop_not_empty: assert property (@(posedge clk) disable iff (reset)
        q_pop |-> !q_empty)
        else begin
            fail_count++;
            $error("pending-load queue popped while empty");
        end

endmodule

bind lsu_unit lsu_unit_props props_inst (
    .clk            (clk),
    .reset          (reset),
    .dispatch_valid (dispatch_valid),
    .dispatch       (dispatch),
    .dispatch_ready (dispatch_ready),
    .commit_valid   (commit_valid),
    .commit         (commit),
    .commit_ready   (commit_ready),
    .q_pop          (q_pop),
    .q_empty        (q_empty)
);

// ==== lsu_unit_tb.sv ====
// load/store unit testbench
`include "lsu_defines.svh"

module lsu_unit_tb;

    localparam int NUM_ROWS = 16;
    localparam int TIMEOUT  = 400;

    // {is_load, is_fence}
    localparam logic [1:0] K_ST = 2'b00;
    localparam logic [1:0] K_FN = 2'b01;
    localparam logic [1:0] K_LD = 2'b10;

    // {unsigned, size}
    localparam logic [2:0] OP_B  = 3'b000;
    localparam logic [2:0] OP_H  = 3'b001;
    localparam logic [2:0] OP_W  = 3'b010;
    localparam logic [2:0] OP_BU = 3'b100;
    localparam logic [2:0] OP_HU = 3'b101;

    typedef struct packed {
        logic [31:0]        due;
        mem_pkg::mem_rsp_t  rsp;
    } rsp_entry_t;

    logic                   clk;
    logic                   reset;
    logic                   dispatch_valid;
    lsu_pkg::lsu_dispatch_t dispatch;
    logic                   dispatch_ready;
    logic                   mem_req_valid;
    mem_pkg::mem_req_t      mem_req;
    logic                   mem_req_ready;
    logic                   mem_rsp_valid;
    mem_pkg::mem_rsp_t      mem_rsp;
    logic                   mem_rsp_ready;
    logic                   commit_valid;
    lsu_pkg::lsu_commit_t   commit;
    logic                   commit_ready;

    lsu_pkg::lsu_dispatch_t rows [NUM_ROWS];
    logic [31:0]            mem [64];
    lsu_pkg::lsu_commit_t   exp_ld [$];
    lsu_pkg::lsu_commit_t   exp_st [$];
    rsp_entry_t             rsp_q [$];
    int                     seed = 93;
    int                     cycle;
    int                     outstanding;
    int                     cur_row;
    logic                   commit_due = 1'b0;

    tb_clock clock_inst (.clk(clk));

    lsu_unit lsu_unit_inst (.*);

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("sim failed");
        $fatal(1);
    endtask

    task automatic check_mem_req(input string name, input mem_pkg::mem_req_t exp,
                                 input mem_pkg::mem_req_t act);
        if (act !== exp) begin
            abort_run($sformatf("error %s: expected %h, actual %h", name, exp, act));
        end
    endtask

    task automatic check_commit(input string name, input lsu_pkg::lsu_commit_t exp,
                                input lsu_pkg::lsu_commit_t act);
        if (act !== exp) begin
            abort_run($sformatf("error %s: expected %h, actual %h", name, exp, act));
        end
    endtask

    // lane 0 operands come before lane 1
    function automatic lsu_pkg::lsu_dispatch_t make_instr(input logic [1:0] kind,
            input logic [2:0] op, input logic [1:0] tm, input logic [31:0] a0,
            input logic [31:0] a1, input logic [31:0] imm, input logic [31:0] d0,
            input logic [31:0] d1, input logic [4:0] rd, input logic [1:0] wid);
        return {wid, 32'h0, tm, rd, kind, op, a1, a0, d1, d0, imm};
    endfunction

    function automatic logic [31:0] narrow(input logic [31:0] w, input logic [1:0] al,
                                           input logic [2:0] op);
        logic [31:0] s;
        s = w >> (8 * al);
        case (op[1:0])
            2'd0: return op[2] ? {24'd0, s[7:0]} : {{24{s[7]}}, s[7:0]};
            2'd1: return op[2] ? {16'd0, s[15:0]} : {{16{s[15]}}, s[15:0]};
            default: return w;
        endcase
    endfunction

    function automatic mem_pkg::mem_req_t expect_req(input lsu_pkg::lsu_dispatch_t d);
        mem_pkg::mem_req_t r;
        logic [31:0]       a;
        r.rw   = !d.is_load;
        r.mask = d.tmask;
        for (int i = 0; i < `LSU_NUM_LANES; i++) begin
            a = d.rs1[i] + d.imm;
            r.addr[i] = a[31:2];
            case (d.op.st.size)
                2'd0: r.byteen[i] = 4'b0001 << a[1:0];
                2'd1: r.byteen[i] = 4'b0011 << a[1:0];
                default: r.byteen[i] = 4'b1111;
            endcase
            r.data[i] = d.rs2[i] << (8 * a[1:0]);
        end
        return r;
    endfunction

    // memory model and scoreboard
    always @(posedge clk) begin
        mem_pkg::mem_req_t    exp_req;
        rsp_entry_t           ent;
        lsu_pkg::lsu_commit_t ec;
        logic [31:0]          a;
        logic                 d_fire;
        logic                 m_fire;
        logic                 r_fire;

        cycle = cycle + 1;
        d_fire = !reset && dispatch_valid && dispatch_ready;
        m_fire = !reset && mem_req_valid && mem_req_ready;
        r_fire = !reset && mem_rsp_valid && mem_rsp_ready;
        // a response or store transfer shows up as a valid commit one cycle later
        if (commit_due && !commit_valid) begin
            abort_run("commit did not become valid one cycle after its transfer");
        end
        commit_due = r_fire || (d_fire && !dispatch.is_load);
        if (m_fire != (d_fire && !dispatch.is_fence)) begin
            abort_run("memory request transfer did not match a dispatch transfer");
        end
        ec = {dispatch.wid, dispatch.pc, dispatch.tmask, dispatch.rd, dispatch.is_load, 64'd0};
        if (d_fire && dispatch.is_fence) begin
            if (mem_req_valid || outstanding != 0) begin
                abort_run("fence accepted with a load outstanding or a memory request");
            end
            exp_st.push_back(ec);
        end
        if (m_fire) begin
            exp_req = expect_req(dispatch);
            check_mem_req($sformatf("request row %0d", cur_row), exp_req, mem_req);
            ent.due = cycle + ($random(seed) & 7);
            ent.rsp = '0;
            for (int i = 0; i < `LSU_NUM_LANES; i++) begin
                a = dispatch.rs1[i] + dispatch.imm;
                if (dispatch.tmask[i] && dispatch.is_load) begin
                    ent.rsp.data[i] = mem[a[7:2]];
                    ec.data[i] = narrow(mem[a[7:2]], a[1:0], dispatch.op);
                end else if (dispatch.tmask[i]) begin
                    for (int b = 0; b < 4; b++) begin
                        if (exp_req.byteen[i][b]) begin
                            mem[a[7:2]][8*b +: 8] = exp_req.data[i][8*b +: 8];
                        end
                    end
                end
            end
            if (dispatch.is_load) begin
                rsp_q.push_back(ent);
                exp_ld.push_back(ec);
                outstanding++;
            end else begin
                exp_st.push_back(ec);
            end
        end
        if (r_fire) begin
            rsp_q.delete(0);
            outstanding--;
        end
        if (!reset && commit_valid && commit_ready) begin
            if ((commit.wb && exp_ld.size() == 0) || (!commit.wb && exp_st.size() == 0)) begin
                abort_run("commit arrived with no instruction waiting for it");
            end
            if (commit.wb) begin
                ec = exp_ld.pop_front();
            end else begin
                ec = exp_st.pop_front();
            end
            check_commit($sformatf("commit row %0d", (ec.pc - 32'h1000) >> 2), ec, commit);
        end
    end

    // memory side and commit back-pressure
    always @(negedge clk) begin
        mem_req_ready = ($random(seed) & 3) != 0;
        commit_ready  = ($random(seed) & 3) != 0;
        if (rsp_q.size() > 0 && cycle >= rsp_q[0].due) begin
            mem_rsp_valid = 1'b1;
            mem_rsp       = rsp_q[0].rsp;
        end else begin
            mem_rsp_valid = 1'b0;
        end
    end

    initial begin
        int waited;

        reset          = 1'b1;
        dispatch_valid = 1'b0;
        dispatch       = '0;
        mem_req_ready  = 1'b0;
        mem_rsp_valid  = 1'b0;
        mem_rsp        = '0;
        commit_ready   = 1'b0;
        cycle          = 0;
        outstanding    = 0;
        cur_row        = 0;
        for (int i = 0; i < 64; i++) begin
            mem[i] = {8'(i * 37), 8'(~i), 8'(i ^ 8'hc3), 8'(i + 8'h80)};
        end

        // kind, op, tmask, rs1 lane 0/1, imm, rs2 lane 0/1, rd, wid
        rows[0]  = make_instr(K_ST, OP_W, 2'b11, 'h20, 'h40, 'h0, 'h11223344, 'h8899aabb, 5'd0, 2'd0);
        rows[1]  = make_instr(K_LD, OP_W, 2'b11, 'h20, 'h40, 'h0, 'h0, 'h0, 5'd5, 2'd0);
        rows[2]  = make_instr(K_ST, OP_B, 2'b11, 'h60, 'h82, 'h1, 'h123456f1, 'h71, 5'd0, 2'd1);
        rows[3]  = make_instr(K_ST, OP_H, 2'b11, 'h62, 'h80, 'h0, 'h8001, 'hffff7ffe, 5'd0, 2'd1);
        rows[4]  = make_instr(K_LD, OP_B, 2'b11, 'h60, 'h82, 'h1, 'h0, 'h0, 5'd6, 2'd1);
        rows[5]  = make_instr(K_LD, OP_BU, 2'b11, 'h60, 'h82, 'h1, 'h0, 'h0, 5'd7, 2'd1);
        rows[6]  = make_instr(K_LD, OP_H, 2'b11, 'h62, 'h80, 'h0, 'h0, 'h0, 5'd8, 2'd1);
        rows[7]  = make_instr(K_LD, OP_HU, 2'b11, 'h62, 'h80, 'h0, 'h0, 'h0, 5'd9, 2'd1);
        rows[8]  = make_instr(K_ST, OP_W, 2'b01, 'h90, 'ha0, 'h0, 'hcafe0001, 'hdead0002, 5'd0, 2'd2);
        rows[9]  = make_instr(K_LD, OP_W, 2'b10, 'h90, 'ha0, 'h0, 'h0, 'h0, 5'd10, 2'd2);
        rows[10] = make_instr(K_LD, OP_W, 2'b11, 'hc4, 'hd0, 'hfffffffc, 'h0, 'h0, 5'd11, 2'd2);
        rows[11] = make_instr(K_LD, OP_B, 2'b11, 'h10, 'h1c, 'h2, 'h0, 'h0, 5'd12, 2'd3);
        rows[12] = make_instr(K_FN, OP_B, 2'b11, 'h0, 'h0, 'h0, 'h0, 'h0, 5'd0, 2'd3);
        rows[13] = make_instr(K_ST, OP_B, 2'b11, 'h2d, 'h33, 'h3, 'h55, 'h9a, 5'd0, 2'd3);
        rows[14] = make_instr(K_LD, OP_B, 2'b11, 'h2d, 'h33, 'h3, 'h0, 'h0, 5'd14, 2'd3);
        rows[15] = make_instr(K_FN, OP_B, 2'b01, 'h0, 'h0, 'h0, 'h0, 'h0, 5'd0, 2'd0);

        repeat (2) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        for (int pass = 0; pass < 2; pass++) begin
            for (int r = 0; r < NUM_ROWS; r++) begin
                cur_row        = pass * NUM_ROWS + r;
                dispatch       = rows[r];
                dispatch.pc    = 32'h1000 + 4 * cur_row;
                dispatch_valid = 1'b1;
                waited         = 0;
                do begin
                    @(posedge clk);
                    waited++;
                    if (waited > TIMEOUT) begin
                        abort_run($sformatf("row %0d was not accepted in time", cur_row));
                    end
                end while (!dispatch_ready);
                @(negedge clk);
            end
        end
        dispatch_valid = 1'b0;

        // let the last responses and commits drain
        waited = 0;
        while (exp_ld.size() + exp_st.size() != 0) begin
            @(posedge clk);
            waited++;
            if (waited > TIMEOUT) begin
                abort_run("expected commits never arrived");
            end
        end
        if (lsu_unit_inst.props_inst.fail_count != 0) begin
            abort_run("a bound assertion failed during the run");
        end else begin
            $display("sim passed");
            $finish;
        end
    end

endmodule

// ==== mem_pkg.sv ====
// memory-side types
`include "lsu_defines.svh"

package mem_pkg;

    typedef logic [`LSU_MEM_ADDR_BITS-1:0] word_addr_t;
    typedef logic [`LSU_WORD_BYTES-1:0]    byteen_t;
    typedef logic [`LSU_XLEN-1:0]          word_t;

    // rw = 1 for a write
    typedef struct packed {
        logic                                   rw;
        logic [`LSU_NUM_LANES-1:0]              mask;
        word_addr_t [`LSU_NUM_LANES-1:0]        addr;
        byteen_t [`LSU_NUM_LANES-1:0]           byteen;
        word_t [`LSU_NUM_LANES-1:0]             data;
    } mem_req_t;

    // one word per lane, in request order
    typedef struct packed {
        word_t [`LSU_NUM_LANES-1:0]             data;
    } mem_rsp_t;

endpackage

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the lsu_unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert -f vlog.f --top-module lsu_unit_tb -o lsu_sim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/lsu_sim > "$log" 2>&1
run_status=$?
cat "$log"

if grep -q "sim failed" "$log"; then
    echo "FAIL: testbench reported an error"
    exit 1
fi

if [ $run_status -ne 0 ]; then
    echo "FAIL: simulator exited with status $run_status"
    exit 1
fi

echo "PASS"
exit 0

// ==== tb_clock.sv ====
// testbench clock source
module tb_clock (
    output logic clk
);

    initial begin
        clk = 1'b0;
    end

    // period of 40
    always begin
        #20 clk = ~clk;
    end

endmodule

// ==== vlog.f ====
+incdir+.
lsu_pkg.sv
mem_pkg.sv
lsu_req_format.sv
lsu_pending_queue.sv
lsu_rsp_format.sv
lsu_unit.sv
tb_clock.sv
lsu_unit_props.sv
lsu_unit_tb.sv
